// File: hw/pwm_settings.svh
`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

// Number of cascaded H-bridge cells
`define PWM_NUM_CELLS 4

// Angle resolution, 4096 counts per turn
`define PWM_ANGLE_W 12

// Carrier and reference width
`define PWM_CARRIER_W 7
`define PWM_CARRIER_MAX 100   // Peak of the triangle, period is twice this

// Amplitude width, 64 is full scale
`define PWM_AMP_W 7
`define PWM_AMP_FULL 64

// Peak of the stored sine table
`define PWM_SINE_PEAK 32

// Gate conditioning, in clk cycles
`define PWM_FILTER_N 3
`define PWM_DEAD_CYCLES 4

`endif

// File: hw/pwm_pkg.sv
`default_nettype none

`include "pwm_settings.svh"

package pwm_pkg;

    localparam int NUM_CELLS = `PWM_NUM_CELLS;

    // Setpoint taken through the valid/ready handshake
    typedef struct packed {
        logic [`PWM_ANGLE_W-1:0] step;       // Angle increment per carrier period
        logic [`PWM_AMP_W-1:0]   amplitude;  // 64 is full scale
        logic [`PWM_ANGLE_W-1:0] phase;      // Start angle
    } setpoint_t;

    // Sine references shared by every cell
    typedef struct packed {
        logic [`PWM_CARRIER_W-1:0] ref_a;
        logic [`PWM_CARRIER_W-1:0] ref_b;
        logic [`PWM_CARRIER_W-1:0] ref_c;
    } phase_refs_t;

    // Gates of one cell, upper and lower switch per leg
    typedef struct packed {
        logic g1_a;
        logic g2_a;
        logic g1_b;
        logic g2_b;
        logic g1_c;
        logic g2_c;
    } leg_gates_t;

    typedef leg_gates_t [NUM_CELLS-1:0] cell_gates_t;

endpackage

`default_nettype wire

// File: hw/reference_gen.sv
`default_nettype none

`include "pwm_settings.svh"

module reference_gen (
    input  logic                clk,
    input  logic                reset,
    input  pwm_pkg::setpoint_t  setpoint,
    input  logic                setpoint_valid,
    output logic                setpoint_ready,
    output pwm_pkg::phase_refs_t phase_refs
);

    import pwm_pkg::*;

    localparam int ANGLE_W = `PWM_ANGLE_W;
    localparam int QUARTER = 2 ** (ANGLE_W - 2);
    localparam int PERIOD = 2 * `PWM_CARRIER_MAX;
    localparam int MID = `PWM_CARRIER_MAX / 2;
    localparam logic [ANGLE_W-1:0] SHIFT_B = ANGLE_W'(1365);  // 120 degrees
    localparam logic [ANGLE_W-1:0] SHIFT_C = ANGLE_W'(2731);  // 240 degrees

    logic [ANGLE_W-1:0]     step_q;
    logic [`PWM_AMP_W-1:0]  amp_q;
    logic [ANGLE_W-1:0]     angle_q;
    logic [$clog2(PERIOD)-1:0] period_cnt;
    logic                   transfer;
    logic [ANGLE_W-1:0]     angles [3];
    logic [`PWM_CARRIER_W-1:0] refs [3];

    // Quarter wave, index 0 to QUARTER inclusive
    logic [5:0] quarter_rom [QUARTER+1];

    function automatic logic [5:0] quarter_value(input int idx);
        real x;
        x = 2.0 * 3.14159265358979 * real'(idx) / real'(4 * QUARTER);
        return 6'($rtoi(real'(`PWM_SINE_PEAK) * $sin(x) + 0.5));
    endfunction

    initial begin
        for (int i = 0; i <= QUARTER; i++) begin
            quarter_rom[i] = quarter_value(i);
        end
    end

    assign transfer = setpoint_valid && setpoint_ready;

    // Ready drops for one cycle after each acceptance
    always_ff @(posedge clk) begin
        if (reset) begin
            setpoint_ready <= 1'b0;
        end else begin
            setpoint_ready <= !transfer;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step_q     <= '0;
            amp_q      <= '0;
            angle_q    <= '0;
            period_cnt <= '0;
        end else begin
            period_cnt <= (period_cnt == PERIOD - 1) ? '0 : period_cnt + 1'b1;
            if (transfer) begin
                step_q  <= setpoint.step;
                amp_q   <= setpoint.amplitude;
                angle_q <= setpoint.phase;     // New start angle wins over the step
            end else if (period_cnt == PERIOD - 1) begin
                angle_q <= angle_q + step_q;   // Lands on the master valley
            end
        end
    end

    assign angles[0] = angle_q;
    assign angles[1] = angle_q + SHIFT_B;
    assign angles[2] = angle_q + SHIFT_C;

    // Fold into the quarter table, then scale around the carrier midpoint
    always_comb begin
        logic [ANGLE_W-3:0] low;
        int idx;
        int s;
        int prod;
        for (int p = 0; p < 3; p++) begin
            low = angles[p][ANGLE_W-3:0];
            idx = angles[p][ANGLE_W-2] ? QUARTER - int'(low) : int'(low);
            s = int'(quarter_rom[idx]);
            if (angles[p][ANGLE_W-1]) begin
                s = -s;                        // Second half turn
            end
            prod = int'(amp_q) * s;
            refs[p] = `PWM_CARRIER_W'(MID + prod / `PWM_AMP_FULL);  // Truncates toward zero
        end
    end

    always_ff @(posedge clk) begin
        phase_refs.ref_a <= refs[0];
        phase_refs.ref_b <= refs[1];
        phase_refs.ref_c <= refs[2];
    end

    amp_in_range: assert property (@(posedge clk) disable iff (reset)
        transfer |=> amp_q <= `PWM_AMP_W'(`PWM_AMP_FULL));

endmodule

`default_nettype wire

// File: hw/carrier_cell.sv
`default_nettype none

`include "pwm_settings.svh"

module carrier_cell #(
    parameter int CELL_INDEX = 0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  pwm_pkg::phase_refs_t phase_refs,
    output pwm_pkg::leg_gates_t  leg_gates
);

    import pwm_pkg::*;

    localparam int MAX = `PWM_CARRIER_MAX;
    localparam int PERIOD = 2 * MAX;
    localparam int POS = CELL_INDEX * PERIOD / NUM_CELLS;  // Phase shift in cycles

    // Starting point on the triangle for this cell
    localparam logic [`PWM_CARRIER_W-1:0] START =
        `PWM_CARRIER_W'((POS < MAX) ? POS : PERIOD - POS);
    localparam logic START_UP = (POS < MAX);

    logic [`PWM_CARRIER_W-1:0] carrier;
    logic                      count_up;

    always_ff @(posedge clk) begin
        if (reset) begin
            carrier  <= START;
            count_up <= START_UP;
        end else if (count_up) begin
            carrier <= carrier + 1'b1;
            if (carrier == `PWM_CARRIER_W'(MAX - 1)) begin
                count_up <= 1'b0;              // Turn at the peak
            end
        end else begin
            carrier <= carrier - 1'b1;
            if (carrier == `PWM_CARRIER_W'(1)) begin
                count_up <= 1'b1;              // Turn at the valley
            end
        end
    end

    // Complementary gates per leg
    always_comb begin
        leg_gates.g1_a = phase_refs.ref_a >= carrier;
        leg_gates.g2_a = !leg_gates.g1_a;
        leg_gates.g1_b = phase_refs.ref_b >= carrier;
        leg_gates.g2_b = !leg_gates.g1_b;
        leg_gates.g1_c = phase_refs.ref_c >= carrier;
        leg_gates.g2_c = !leg_gates.g1_c;
    end

    carrier_in_range: assert property (@(posedge clk) disable iff (reset)
        carrier <= `PWM_CARRIER_W'(MAX));

endmodule

`default_nettype wire

// File: hw/gate_conditioner.sv
`default_nettype none

`include "pwm_settings.svh"

module gate_conditioner (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 shoot,
    input  pwm_pkg::cell_gates_t cell_gates,
    output pwm_pkg::cell_gates_t gates
);

    import pwm_pkg::*;

    localparam int BITS = $bits(cell_gates_t);
    localparam int FILT_W = $clog2(`PWM_FILTER_N);
    localparam int DEAD_W = $clog2(`PWM_DEAD_CYCLES + 1);

    logic [BITS-1:0]   raw;
    logic [BITS-1:0]   filtered;
    logic [BITS-1:0]   dead_done;
    logic [FILT_W-1:0] filt_cnt [BITS];
    logic [DEAD_W-1:0] dead_cnt [BITS];
    logic              shoot_q;
    logic [NUM_CELLS*3-1:0] overlap;

    assign raw = cell_gates;

    // A level passes once it has differed from the filtered value for N cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            filtered <= '0;
            for (int i = 0; i < BITS; i++) begin
                filt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BITS; i++) begin
                if (raw[i] == filtered[i]) begin
                    filt_cnt[i] <= '0;
                end else if (filt_cnt[i] == FILT_W'(`PWM_FILTER_N - 1)) begin
                    filtered[i] <= raw[i];
                    filt_cnt[i] <= '0;
                end else begin
                    filt_cnt[i] <= filt_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Turn-on delay, falling edges pass straight through
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BITS; i++) begin
                dead_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BITS; i++) begin
                if (!filtered[i]) begin
                    dead_cnt[i] <= '0;
                end else if (!dead_done[i]) begin
                    dead_cnt[i] <= dead_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < BITS; i++) begin
            dead_done[i] = dead_cnt[i] == DEAD_W'(`PWM_DEAD_CYCLES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            shoot_q <= 1'b0;
        end else begin
            shoot_q <= shoot;
        end
    end

    assign gates = filtered & dead_done & {BITS{shoot_q}};

    // Both switches of a leg on at once would short the DC link
    always_comb begin
        for (int c = 0; c < NUM_CELLS; c++) begin
            overlap[3*c]     = gates[c].g1_a && gates[c].g2_a;
            overlap[3*c + 1] = gates[c].g1_b && gates[c].g2_b;
            overlap[3*c + 2] = gates[c].g1_c && gates[c].g2_c;
        end
    end

    no_shoot_through: assert property (@(posedge clk) disable iff (reset)
        overlap == '0);

endmodule

`default_nettype wire

// File: hw/pwm_inverter.sv
`default_nettype none

`include "pwm_settings.svh"

module pwm_inverter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 shoot,            // Gates enabled while high
    input  pwm_pkg::setpoint_t   setpoint,
    input  logic                 setpoint_valid,
    output logic                 setpoint_ready,
    output pwm_pkg::cell_gates_t gates
);

    import pwm_pkg::*;

    phase_refs_t phase_refs;
    cell_gates_t raw_gates;   // Straight from the comparators

    reference_gen i_reference_gen (
        .clk            (clk),
        .reset          (reset),
        .setpoint       (setpoint),
        .setpoint_valid (setpoint_valid),
        .setpoint_ready (setpoint_ready),
        .phase_refs     (phase_refs)
    );

    // One cell per cascaded bridge, each with its own carrier shift
    for (genvar k = 0; k < `PWM_NUM_CELLS; k++) begin : g_cell
        carrier_cell #(
            .CELL_INDEX (k)
        ) i_carrier_cell (
            .clk        (clk),
            .reset      (reset),
            .phase_refs (phase_refs),
            .leg_gates  (raw_gates[k])
        );
    end

    gate_conditioner i_gate_conditioner (
        .clk        (clk),
        .reset      (reset),
        .shoot      (shoot),
        .cell_gates (raw_gates),
        .gates      (gates)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2) clk = ~clk;  // Half period per phase
    end

endmodule

`default_nettype wire

// File: testbench/tb_pwm_inverter.sv
`default_nettype none

`include "pwm_settings.svh"

module tb_pwm_inverter;

    import pwm_pkg::*;

    localparam int PERIOD = 2 * `PWM_CARRIER_MAX;   // Carrier period in cycles
    localparam int MID = `PWM_CARRIER_MAX / 2;
    localparam int FULL_TURN = 1 << `PWM_ANGLE_W;
    localparam int SHIFT_B = 1365;
    localparam int SHIFT_C = 2731;
    localparam int DEAD = `PWM_DEAD_CYCLES;
    localparam int RESET_CYCLES = 8;
    localparam int SETTLE = PERIOD;
    localparam int ANGLE_TRIALS = 4;
    localparam int DEAD_PERIODS = 6;
    localparam int DEAD_SETTLE = 20;
    localparam real PI = 3.14159265358979323846;
    localparam logic [31:0] SEED = 32'h0e36_2230;

    // Cycle budget of each test
    localparam int LEN_SEND = 4;
    localparam int LEN_RESET = RESET_CYCLES + 4;
    localparam int LEN_SHOOT = LEN_SEND + 2 * PERIOD;
    localparam int LEN_DUTY = LEN_SEND + SETTLE + PERIOD + 2;
    localparam int LEN_HANDSHAKE = 6 + SETTLE + PERIOD;
    localparam int LEN_DEAD = LEN_SEND + DEAD_SETTLE + DEAD_PERIODS * PERIOD;
    localparam int TOTAL = LEN_RESET + LEN_SHOOT + LEN_DUTY * (1 + ANGLE_TRIALS)
                         + LEN_HANDSHAKE + LEN_DEAD;
    localparam int CYCLE_LIMIT = TOTAL + TOTAL / 10;

    logic        clk;
    logic        reset;
    logic        shoot;
    setpoint_t   setpoint;
    logic        setpoint_valid;
    logic        setpoint_ready;
    cell_gates_t gates;
    int          cycle_count = 0;

    tb_clock #(.PERIOD(8)) i_tb_clock (.clk(clk));

    pwm_inverter i_pwm_inverter (
        .clk            (clk),
        .reset          (reset),
        .shoot          (shoot),
        .setpoint       (setpoint),
        .setpoint_valid (setpoint_valid),
        .setpoint_ready (setpoint_ready),
        .gates          (gates)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_run($sformatf("timeout: no end of the tests after %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic compare_gates(input string name, input cell_gates_t got,
                                 input cell_gates_t expected);
        if (got !== expected) begin
            fail_run($sformatf("error at %0t: %s is %h, expected %h",
                               $time, name, got, expected));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int expected);
        if (got != expected) begin
            fail_run($sformatf("error at %0t: %s is %0d, expected %0d",
                               $time, name, got, expected));
        end
    endtask

    task automatic compare_ready(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            fail_run($sformatf("error at %0t: %s is %b, expected %b",
                               $time, name, got, expected));
        end
    endtask

    function automatic setpoint_t make_setpoint(input int step, input int amp, input int phase);
        setpoint_t sp;
        sp.step = `PWM_ANGLE_W'(step);
        sp.amplitude = `PWM_AMP_W'(amp);
        sp.phase = `PWM_ANGLE_W'(phase);
        return sp;
    endfunction

    // Sine rounded with halves away from zero
    function automatic int sine_value(input int angle);
        real v;
        v = real'(`PWM_SINE_PEAK) * $sin(2.0 * PI * real'(angle) / real'(FULL_TURN));
        if (v >= 0.0) begin
            return $rtoi(v + 0.5);
        end
        return -$rtoi(0.5 - v);
    endfunction

    function automatic int reference_for(input int amp, input int angle);
        return MID + (amp * sine_value(angle % FULL_TURN)) / `PWM_AMP_FULL;
    endfunction

    function automatic logic upper_gate(input leg_gates_t g, input int leg);
        return (leg == 0) ? g.g1_a : (leg == 1) ? g.g1_b : g.g1_c;
    endfunction

    function automatic logic lower_gate(input leg_gates_t g, input int leg);
        return (leg == 0) ? g.g2_a : (leg == 1) ? g.g2_b : g.g2_c;
    endfunction

    function automatic string leg_name(input int leg);
        return (leg == 0) ? "a" : (leg == 1) ? "b" : "c";
    endfunction

    task automatic send_setpoint(input setpoint_t sp);
        logic taken;
        taken = 1'b0;
        @(negedge clk);
        setpoint = sp;
        setpoint_valid = 1'b1;
        while (!taken) begin
            taken = setpoint_ready;  // Transfer on the next rising edge
            @(negedge clk);
        end
        setpoint_valid = 1'b0;
    endtask

    // Settle and then count gate highs over one carrier period for both gates of every leg
    task automatic check_duty(input setpoint_t sp);
        int refs [3];
        int g1_cnt [NUM_CELLS][3];
        int g2_cnt [NUM_CELLS][3];
        cell_gates_t sample;
        refs[0] = reference_for(int'(sp.amplitude), int'(sp.phase));
        refs[1] = reference_for(int'(sp.amplitude), int'(sp.phase) + SHIFT_B);
        refs[2] = reference_for(int'(sp.amplitude), int'(sp.phase) + SHIFT_C);
        for (int c = 0; c < NUM_CELLS; c++) begin
            for (int l = 0; l < 3; l++) begin
                g1_cnt[c][l] = 0;
                g2_cnt[c][l] = 0;
            end
        end
        repeat (SETTLE) @(negedge clk);
        repeat (PERIOD) begin
            @(negedge clk);
            sample = gates;
            for (int c = 0; c < NUM_CELLS; c++) begin
                for (int l = 0; l < 3; l++) begin
                    g1_cnt[c][l] += int'(upper_gate(sample[c], l));
                    g2_cnt[c][l] += int'(lower_gate(sample[c], l));
                end
            end
        end
        for (int c = 0; c < NUM_CELLS; c++) begin
            for (int l = 0; l < 3; l++) begin
                // Carrier sits at or below ref for 2 * ref + 1 cycles
                compare_count($sformatf("gates[%0d].g1_%s count", c, leg_name(l)),
                              g1_cnt[c][l], 2 * refs[l] + 1 - DEAD);
                compare_count($sformatf("gates[%0d].g2_%s count", c, leg_name(l)),
                              g2_cnt[c][l], PERIOD - (2 * refs[l] + 1) - DEAD);
            end
        end
    endtask

    task automatic test_reset();
        $display("test 1: reset");
        repeat (RESET_CYCLES) @(negedge clk);
        compare_ready("setpoint_ready", setpoint_ready, 1'b0);
        compare_gates("gates", gates, '0);
        reset = 1'b0;
        @(negedge clk);
        compare_ready("setpoint_ready", setpoint_ready, 1'b1);
        compare_gates("gates", gates, '0);
    endtask

    task automatic test_shoot_low();
        $display("test 2: shoot low");
        send_setpoint(make_setpoint(0, 50, 300));
        repeat (2 * PERIOD) begin
            @(negedge clk);
            compare_gates("gates", gates, '0);
        end
    endtask

    task automatic test_zero_amplitude();
        setpoint_t sp;
        $display("test 3: zero amplitude");
        sp = make_setpoint(0, 0, 0);
        @(negedge clk);
        shoot = 1'b1;
        send_setpoint(sp);
        check_duty(sp);
    endtask

    task automatic test_fixed_angle();
        setpoint_t sp;
        $display("test 4: fixed angle");
        for (int i = 0; i < ANGLE_TRIALS; i++) begin
            sp = make_setpoint(0, int'($urandom % (`PWM_AMP_FULL + 1)),
                               int'($urandom % FULL_TURN));
            send_setpoint(sp);
            check_duty(sp);
        end
    endtask

    task automatic test_handshake();
        logic exp_ready [5] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
        setpoint_t first;
        setpoint_t second;
        $display("test 5: handshake");
        first = make_setpoint(0, 64, 1024);
        second = make_setpoint(0, 0, 0);
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            compare_ready("setpoint_ready", setpoint_ready, exp_ready[i]);
            if (i == 0) begin
                setpoint = first;
                setpoint_valid = 1'b1;
            end else if (i == 1) begin
                setpoint = second;  // Valid stays high through the ready gap
            end else if (i == 3) begin
                setpoint_valid = 1'b0;
            end
        end
        // References differ from the first setpoint, so only a taken second one matches
        check_duty(second);
    endtask

    task automatic test_dead_time();
        int fall_at [NUM_CELLS][3];
        logic prev_g1 [NUM_CELLS][3];
        logic prev_g2 [NUM_CELLS][3];
        logic g1;
        logic g2;
        int rises;
        cell_gates_t sample;
        $display("test 6: dead time");
        rises = 0;
        send_setpoint(make_setpoint(150, 60, 0));
        repeat (DEAD_SETTLE) @(negedge clk);
        sample = gates;
        for (int c = 0; c < NUM_CELLS; c++) begin
            for (int l = 0; l < 3; l++) begin
                fall_at[c][l] = -DEAD;
                prev_g1[c][l] = upper_gate(sample[c], l);
                prev_g2[c][l] = lower_gate(sample[c], l);
            end
        end
        for (int t = 0; t < DEAD_PERIODS * PERIOD; t++) begin
            @(negedge clk);
            sample = gates;
            for (int c = 0; c < NUM_CELLS; c++) begin
                for (int l = 0; l < 3; l++) begin
                    g1 = upper_gate(sample[c], l);
                    g2 = lower_gate(sample[c], l);
                    if (g1 && g2) begin
                        fail_run($sformatf("cell %0d leg %s has both gates on at %0t",
                                           c, leg_name(l), $time));
                    end
                    if (prev_g2[c][l] && !g2) begin
                        fall_at[c][l] = t;
                    end
                    if (g1 && !prev_g1[c][l]) begin
                        rises++;
                        if (t - fall_at[c][l] < DEAD) begin
                            fail_run($sformatf("cell %0d leg %s g1 rose %0d cycles after g2 fell",
                                               c, leg_name(l), t - fall_at[c][l]));
                        end
                    end
                    prev_g1[c][l] = g1;
                    prev_g2[c][l] = g2;
                end
            end
        end
        if (rises == 0) begin
            fail_run("no rising edge of any g1 appeared during the dead-time test");
        end
    endtask

    initial begin
        reset = 1'b1;
        shoot = 1'b0;
        setpoint = '0;
        setpoint_valid = 1'b0;
        void'($urandom(SEED));
        test_reset();
        test_shoot_low();
        test_zero_amplitude();
        test_fixed_angle();
        test_handshake();
        test_dead_time();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/pwm_pkg.sv
hw/reference_gen.sv
hw/carrier_cell.sv
hw/gate_conditioner.sv
hw/pwm_inverter.sv
testbench/tb_clock.sv
testbench/tb_pwm_inverter.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_pwm_inverter
FILELIST  := src.f
OBJ_DIR   := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/pwm_settings.svh
BINARY    := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
